// ==== src.f ====
+incdir+testbench
verilog/cpuPkg.sv
verilog/regFile.sv
verilog/controlUnit.sv
verilog/decode.sv
verilog/alu.sv
verilog/execStage.sv
verilog/fetchUnit.sv
verilog/memArbiter.sv
verilog/cpuTop.sv
testbench/cpuTb.sv

// ==== testbench/isaModel.svh ====
// ISA reference model; the includer imports cpuPkg; memory is 256 words, addresses wrap at 8 bits
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// runs img from pc 0 until HALT or an illegal opcode, returns the error flag
function automatic logic runProgram(input logic [255:0][15:0] img,
                                    output logic [255:0][15:0] fin);
   logic [15:0] r [8];
   logic [15:0] pc, w, addr, sImm5, sImm8, sImm11;
   logic [2:0]  rs, rt, rd;
   logic        done, errFlag;
   int          steps;
   fin     = img;
   pc      = 16'h0000;
   done    = 1'b0;
   errFlag = 1'b0;
   steps   = 0;
   for (int i = 0; i < 8; i++) begin
      r[i] = 16'h0000;   // registers clear on reset
   end
   while (!done && steps < 5000) begin   // bound keeps a bad image from looping forever
      w      = fin[pc[7:0]];
      rs     = w[10:8];
      rt     = w[7:5];
      rd     = w[4:2];
      sImm5  = {{11{w[4]}}, w[4:0]};
      sImm8  = {{8{w[7]}}, w[7:0]};
      sImm11 = {{5{w[10]}}, w[10:0]};
      addr   = r[rs] + sImm5;   // ld/st effective address
      pc     = pc + 16'd1;      // targets are relative to the next pc
      case (w[15:11])
         OpHalt: done = 1'b1;
         OpNop:  ;
         OpAddi: r[rt] = r[rs] + sImm5;
         OpSubi: r[rt] = r[rs] - sImm5;
         OpRfmt: begin
            case (w[1:0])
               FnAdd: r[rd] = r[rs] + r[rt];
               FnSub: r[rd] = r[rs] - r[rt];
               FnXor: r[rd] = r[rs] ^ r[rt];
               FnAnd: r[rd] = r[rs] & r[rt];
            endcase
         end
         OpLbi:  r[rs] = sImm8;
         OpSlbi: r[rs] = (r[rs] << 8) | {8'h00, w[7:0]};   // shift up and or in the immediate
         OpLd:   r[rt] = fin[addr[7:0]];
         OpSt:   fin[addr[7:0]] = r[rt];
         OpBeqz: if (r[rs] == 16'h0000) pc = pc + sImm8;
         OpBnez: if (r[rs] != 16'h0000) pc = pc + sImm8;
         OpJ:    pc = pc + sImm11;
         default: begin
            done    = 1'b1;   // illegal opcode stops with no side effect
            errFlag = 1'b1;
         end
      endcase
      steps++;
   end
   return errFlag;
endfunction

`endif

// ==== testbench/cpuTb.sv ====
// self-checking testbench for cpuTop; 256-word memory, code from address 0, data from 0x80
`timescale 1ns/100ps
module cpuTb import cpuPkg::*; ();

   logic        clk;
   logic        arstN;
   logic        memValid, memWrite, memReady;
   logic [15:0] memAddr, memWdata, memRdata;
   logic        halted, err;

   logic [15:0]        mem [256];   // memory model seen by the DUT
   logic [255:0][15:0] image;       // program image being built
   int                 codePtr;
   logic               forceReady;   // 1 keeps memReady high
   logic [31:0]        readyState, codeState;   // two LFSR streams
   logic               prevPending, prevWrite;
   logic [15:0]        prevAddr, prevWdata;

   `include "isaModel.svh"

   cpuTop u_cpuTop (
      .clk(clk), .arstN(arstN),
      .memValid(memValid), .memWrite(memWrite), .memAddr(memAddr),
      .memWdata(memWdata), .memReady(memReady), .memRdata(memRdata),
      .halted(halted), .err(err)
   );

   always #20 clk = ~clk;

   // read data valid in the handshake cycle, writes land on the edge
   assign memRdata = mem[memAddr[7:0]];
   always @(posedge clk) begin
      if (memValid && memReady && memWrite) mem[memAddr[7:0]] <= memWdata;
   end

   // galois form, taps 32 22 2 1
   function automatic logic [31:0] lfsrStep(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   always @(posedge clk) begin
      readyState = lfsrStep(readyState);   // one bit per cycle
      memReady <= forceReady | readyState[0];
   end

   task automatic failRun(input string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic checkValue(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
      if (got !== exp) begin
         failRun($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
      end
   endtask

   // bus must hold still while a request is stalled
   always @(negedge clk) begin
      if (arstN && prevPending) begin
         checkValue("memValid", {15'b0, memValid}, 16'h0001);
         checkValue("memWrite", {15'b0, memWrite}, {15'b0, prevWrite});
         checkValue("memAddr", memAddr, prevAddr);
         if (prevWrite) checkValue("memWdata", memWdata, prevWdata);
      end
      prevPending = arstN && memValid && !memReady;
      prevWrite   = memWrite;
      prevAddr    = memAddr;
      prevWdata   = memWdata;
   end

   task automatic drawBits(input int n, output int bits);
      bits = 0;
      for (int i = 0; i < n; i++) begin
         codeState = lfsrStep(codeState);   // one step per bit taken
         bits = bits * 2 + int'(codeState[0]);
      end
   endtask

   function automatic logic [15:0] encI(opcodeT op, int rs, int rt, int imm);
      return {op, rs[2:0], rt[2:0], imm[4:0]};
   endfunction

   function automatic logic [15:0] encR(int fn, int rs, int rt, int rd);
      return {OpRfmt, rs[2:0], rt[2:0], rd[2:0], fn[1:0]};
   endfunction

   function automatic logic [15:0] encB(opcodeT op, int rs, int imm);   // lbi slbi beqz bnez
      return {op, rs[2:0], imm[7:0]};
   endfunction

   function automatic logic [15:0] encJ(int imm);
      return {OpJ, imm[10:0]};
   endfunction

   task automatic emit(input logic [15:0] w);
      image[codePtr] = w;
      codePtr++;
   endtask

   task automatic clearImage();
      for (int i = 0; i < 256; i++) begin
         image[i] = {~i[7:0], i[7:0]};   // distinct word per address
      end
      codePtr = 0;
   endtask

   task automatic buildArith();
      clearImage();
      emit(encB(OpLbi, 7, 0));
      emit(encB(OpSlbi, 7, 'h80));   // base 0x0080
      emit(encB(OpLbi, 1, 'h35));
      emit(encB(OpLbi, 2, 'hF3));    // sign extends
      emit(encB(OpSlbi, 2, 'h9E));
      emit(encI(OpAddi, 1, 3, 13));
      emit(encI(OpSubi, 2, 4, -7));
      for (int f = 0; f < 4; f++) begin
         emit(encR(f, 1, 2, 5));
         emit(encI(OpSt, 7, 5, f));
      end
      for (int r = 1; r < 5; r++) emit(encI(OpSt, 7, r, r + 3));
      emit({OpHalt, 11'h000});
   endtask

   task automatic buildLoadStore();
      clearImage();
      emit(encB(OpLbi, 7, 0));
      emit(encB(OpSlbi, 7, 'h90));
      emit(encI(OpLd, 7, 1, 0));
      emit(encI(OpLd, 7, 2, -3));
      emit(encR(FnAdd, 1, 2, 3));
      emit(encI(OpSt, 7, 3, 5));
      emit(encI(OpLd, 7, 4, 5));     // load right after a store to the same word
      emit(encI(OpAddi, 4, 4, 1));
      emit(encI(OpSt, 7, 4, -16));
      emit(encI(OpLd, 7, 5, -16));
      emit(encI(OpSt, 7, 5, 15));
      emit(encI(OpSt, 7, 2, -1));
      emit({OpHalt, 11'h000});
   endtask

   task automatic buildBranch();
      clearImage();
      emit(encB(OpLbi, 7, 0));
      emit(encB(OpSlbi, 7, 'hA0));
      emit(encB(OpLbi, 1, 4));       // loop count
      emit(encB(OpLbi, 2, 0));
      emit(encI(OpAddi, 2, 2, 3));   // loop body at 4
      emit(encI(OpSubi, 1, 1, 1));
      emit(encB(OpBeqz, 1, 2));      // exit to 9
      emit(encJ(-4));                // back to 4
      emit(encI(OpSt, 7, 2, 9));     // shadow of j
      emit(encI(OpSt, 7, 2, 0));     // 9
      emit(encB(OpBnez, 2, 1));      // taken
      emit(encI(OpSt, 7, 2, 1));     // skipped
      emit(encB(OpBnez, 3, 1));      // r3 is zero so it falls through
      emit(encI(OpSt, 7, 2, 2));
      emit(encB(OpBeqz, 2, 1));      // falls through
      emit(encI(OpSt, 7, 2, 3));
      emit(encJ(2));                 // forward to 19
      emit(encI(OpSt, 7, 2, 4));
      emit(encI(OpSt, 7, 2, 5));
      emit(encB(OpBeqz, 3, 1));      // taken branch at 19
      emit(encI(OpSt, 7, 2, 6));
      emit(encI(OpSt, 7, 1, 7));
      emit({OpHalt, 11'h000});
   endtask

   task automatic buildIllegal();
      clearImage();
      emit(encB(OpLbi, 7, 0));
      emit(encB(OpSlbi, 7, 'hB0));
      emit(encB(OpLbi, 1, 'h5A));
      emit(encI(OpSt, 7, 1, 0));
      emit(encI(OpAddi, 1, 2, 1));
      emit(encI(OpSt, 7, 2, 1));
      emit({5'b00010, 11'h123});     // unused opcode
      emit(encI(OpSt, 7, 1, 2));     // must never land
      emit({OpHalt, 11'h000});
   endtask

   task automatic buildRandom();
      int k, d, s, t, imm, dest;
      clearImage();
      emit(encB(OpLbi, 7, 0));
      emit(encB(OpSlbi, 7, 'hC0));   // r7 stays the store base
      for (int r = 0; r < 7; r++) begin
         drawBits(8, imm);
         emit(encB(OpLbi, r, imm));
      end
      for (int n = 0; n < 40; n++) begin
         drawBits(3, k);
         drawBits(3, d);
         drawBits(3, s);
         drawBits(3, t);
         dest = d % 7;
         if (k < 2) begin
            drawBits(5, imm);
            emit(encI((k == 0) ? OpAddi : OpSubi, s, dest, imm));
         end else if (k < 6) begin
            emit(encR(k - 2, s, t, dest));
         end else begin
            drawBits(8, imm);
            emit(encB((k == 6) ? OpLbi : OpSlbi, dest, imm));
         end
      end
      for (int r = 0; r < 8; r++) emit(encI(OpSt, 7, r, r));
      emit({OpHalt, 11'h000});
   endtask

   // loads the image under reset, runs it and compares memory and err against the model
   task automatic runTest(input logic randomReady);
      logic [255:0][15:0] expImage;
      logic               expErr;
      int                 cycles;
      expErr = runProgram(image, expImage);
      @(posedge clk);
      arstN <= 1'b0;
      forceReady <= ~randomReady;
      @(negedge clk);
      for (int i = 0; i < 256; i++) mem[i] = image[i];
      repeat (3) @(posedge clk);
      arstN <= 1'b1;
      cycles = 0;
      @(negedge clk);
      while (!halted) begin
         if (cycles >= 5000) failRun("Timeout, halted did not rise within 5000 cycles");
         @(negedge clk);
         cycles++;
      end
      for (int i = 0; i < 256; i++) begin
         checkValue($sformatf("mem[%0d]", i), mem[i], expImage[i]);
      end
      checkValue("err", {15'b0, err}, {15'b0, expErr});
   endtask

   initial begin
      clk         = 1'b0;
      arstN       = 1'b0;
      memReady    = 1'b0;
      forceReady  = 1'b1;
      prevPending = 1'b0;
      readyState  = 32'd77579;
      codeState   = 32'd77579;
      for (int pass = 0; pass < 2; pass++) begin   // second pass with random memReady
         buildArith();
         runTest(pass == 1);
         buildLoadStore();
         runTest(pass == 1);
         buildBranch();
         runTest(pass == 1);
      end
      buildIllegal();
      runTest(1'b1);
      buildRandom();
      runTest(1'b1);
      buildRandom();
      runTest(1'b0);
      $display("Test OK");
      $finish;
   end

endmodule

// ==== verilog/cpuTop.sv ====
// two-stage core on one word-addressed bus; memory sits outside, read data valid with memReady
`timescale 1ns/100ps
module cpuTop (
   input  logic        clk,
   input  logic        arstN,
   output logic        memValid,
   output logic        memWrite,
   output logic [15:0] memAddr,
   output logic [15:0] memWdata,
   input  logic        memReady,
   input  logic [15:0] memRdata,
   output logic        halted,   // level, program done
   output logic        err       // illegal opcode seen
);

   logic        fetchValid, fetchReady;
   logic [15:0] fetchAddr;
   logic        instrValid, instrReady;
   logic [15:0] instr, instrPc;
   logic        redirect;
   logic [15:0] redirectPc;
   logic        dataValid, dataWrite, dataReady;
   logic [15:0] dataAddr, dataWdata;

   fetchUnit u_fetchUnit (
      .clk(clk), .arstN(arstN), .halted(halted),
      .redirect(redirect), .redirectPc(redirectPc),
      .fetchValid(fetchValid), .fetchAddr(fetchAddr),
      .fetchReady(fetchReady), .fetchRdata(memRdata),   // shared read data
      .instrValid(instrValid), .instr(instr), .instrPc(instrPc),
      .instrReady(instrReady)
   );

   execStage u_execStage (
      .clk(clk), .arstN(arstN),
      .instrValid(instrValid), .instr(instr), .instrPc(instrPc),
      .instrReady(instrReady),
      .redirect(redirect), .redirectPc(redirectPc),
      .halted(halted), .err(err),
      .dataValid(dataValid), .dataWrite(dataWrite), .dataAddr(dataAddr),
      .dataWdata(dataWdata), .dataReady(dataReady), .dataRdata(memRdata)
   );

   memArbiter u_memArbiter (
      .fetchValid(fetchValid), .fetchAddr(fetchAddr), .fetchReady(fetchReady),
      .dataValid(dataValid), .dataWrite(dataWrite), .dataAddr(dataAddr),
      .dataWdata(dataWdata), .dataReady(dataReady),
      .memValid(memValid), .memWrite(memWrite), .memAddr(memAddr),
      .memWdata(memWdata), .memReady(memReady)
   );

endmodule

// ==== verilog/memArbiter.sv ====
// combinational fixed priority, data over fetch; relies on requesters holding a pending request
`timescale 1ns/100ps
module memArbiter (
   input  logic        fetchValid,
   input  logic [15:0] fetchAddr,
   output logic        fetchReady,
   input  logic        dataValid,
   input  logic        dataWrite,
   input  logic [15:0] dataAddr,
   input  logic [15:0] dataWdata,
   output logic        dataReady,
   output logic        memValid,
   output logic        memWrite,
   output logic [15:0] memAddr,
   output logic [15:0] memWdata,
   input  logic        memReady
);

   logic dataGrant;   // data wins whenever it asks

   assign dataGrant = dataValid;

   assign memValid = dataValid | fetchValid;
   assign memWrite = dataGrant & dataWrite;   // fetches are always reads
   assign memAddr  = dataGrant ? dataAddr : fetchAddr;
   assign memWdata = dataWdata;               // don't care on reads

   // ready only to the winner
   assign dataReady  = dataGrant & memReady;
   assign fetchReady = ~dataGrant & fetchValid & memReady;

endmodule

// ==== verilog/fetchUnit.sv ====
// one-word prefetch buffer; a new fetch starts only after the buffered word is consumed
`timescale 1ns/100ps
module fetchUnit import cpuPkg::*; (
   input  logic        clk,
   input  logic        arstN,
   input  logic        halted,
   input  logic        redirect,
   input  logic [15:0] redirectPc,
   output logic        fetchValid,
   output logic [15:0] fetchAddr,
   input  logic        fetchReady,
   input  logic [15:0] fetchRdata,
   output logic        instrValid,
   output logic [15:0] instr,
   output logic [15:0] instrPc,
   input  logic        instrReady
);

   fetchStateT  state;
   logic [15:0] pc;        // address of the next word to fetch
   logic [15:0] instrBuf;  // buffered instruction word
   logic [15:0] bufPc;

   // halted masks the request raised in the cycle right after a halt is consumed
   assign fetchValid = (state == FetchReq) & ~halted;
   assign fetchAddr  = pc;
   assign instrValid = (state == FetchHold);   // buffer full
   assign instr      = instrBuf;
   assign instrPc    = bufPc;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state <= FetchIdle;
         pc    <= 16'h0000;
      end else if (redirect) begin
         state <= FetchReq;   // buffer dropped, restart at target
         pc    <= redirectPc;
      end else begin
         case (state)
            FetchIdle: if (!halted) state <= FetchReq;
            FetchReq: begin
               if (halted) begin
                  state <= FetchIdle;
               end else if (fetchReady) begin
                  state <= FetchHold;
                  pc    <= pc + 16'd1;
               end
            end
            FetchHold: if (instrReady) state <= FetchReq;   // refill next cycle
            default:   state <= FetchIdle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (fetchValid && fetchReady) begin
         instrBuf <= fetchRdata;
         bufPc    <= pc;
      end
   end

endmodule

// ==== verilog/execStage.sv ====
// single-pass execute; ld/st stall the stage until dataReady, halt and illegal opcode freeze it
`timescale 1ns/100ps
module execStage import cpuPkg::*; (
   input  logic        clk,
   input  logic        arstN,
   input  logic        instrValid,
   input  logic [15:0] instr,
   input  logic [15:0] instrPc,
   output logic        instrReady,
   output logic        redirect,
   output logic [15:0] redirectPc,
   output logic        halted,
   output logic        err,
   output logic        dataValid,
   output logic        dataWrite,
   output logic [15:0] dataAddr,
   output logic [15:0] dataWdata,
   input  logic        dataReady,
   input  logic [15:0] dataRdata
);

   logic [15:0] opA, opB, storeData, imm8, imm11, aluResult, wbData;
   logic [2:0]  destReg;
   aluOpT       aluOp;
   logic        regWrite, memRead, memWrite;
   logic        branchZero, branchNonZero, jump, halt, illegal;
   logic        isMem, consume, taken, wbEn;

   decode u_decode (
      .clk(clk), .arstN(arstN), .instr(instr),
      .wbData(wbData), .wbEn(wbEn), .wbSel(destReg),
      .opA(opA), .opB(opB), .storeData(storeData), .destReg(destReg),
      .imm8(imm8), .imm11(imm11), .aluOp(aluOp),
      .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite),
      .branchZero(branchZero), .branchNonZero(branchNonZero),
      .jump(jump), .halt(halt), .illegal(illegal)
   );

   alu u_alu (.op(aluOp), .a(opA), .b(opB), .result(aluResult));

   assign isMem = memRead | memWrite;

   // memory request raised the cycle the instruction shows up
   assign dataValid = instrValid & isMem & ~halted;
   assign dataWrite = memWrite;
   assign dataAddr  = aluResult;   // rs + sext(imm5)
   assign dataWdata = storeData;

   // mem ops wait for the bus, everything else goes in one cycle
   assign instrReady = ~halted & (~isMem | dataReady);
   assign consume    = instrValid & instrReady;

   assign wbEn   = consume & regWrite;   // lands on the consume edge
   assign wbData = memRead ? dataRdata : aluResult;

   // branch test on rs
   assign taken = (branchZero & (opA == 16'h0000)) |
                  (branchNonZero & (opA != 16'h0000)) | jump;
   assign redirect   = consume & taken;
   assign redirectPc = instrPc + 16'd1 + (jump ? imm11 : imm8);

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         halted <= 1'b0;
         err    <= 1'b0;
      end else if (consume & (halt | illegal)) begin
         halted <= 1'b1;      // sticky until reset
         err    <= illegal;
      end
   end

endmodule

// ==== verilog/alu.sv ====
// 16-bit combinational alu, no flags; subtraction is a minus b
`timescale 1ns/100ps
module alu import cpuPkg::*; (
   input  aluOpT       op,
   input  logic [15:0] a,
   input  logic [15:0] b,
   output logic [15:0] result
);

   always_comb begin
      case (op)
         AluAdd:   result = a + b;   // also ld/st address
         AluSub:   result = a - b;
         AluXor:   result = a ^ b;
         AluAnd:   result = a & b;
         AluPassB: result = b;
         AluMerge: begin
            // slbi moves the old low byte up and the immediate fills the bottom
            result = {a[7:0], b[7:0]};
         end
         default:  result = 16'h0000;   // unused encodings
      endcase
   end

endmodule

// ==== verilog/decode.sv ====
// decode with register read; writeback enters from execute through wbEn/wbSel/wbData
`timescale 1ns/100ps
module decode import cpuPkg::*; (
   input  logic        clk,
   input  logic        arstN,
   input  logic [15:0] instr,
   input  logic [15:0] wbData,
   input  logic        wbEn,
   input  logic [2:0]  wbSel,
   output logic [15:0] opA,         // rs value
   output logic [15:0] opB,         // second alu operand
   output logic [15:0] storeData,   // rt value for st
   output logic [2:0]  destReg,
   output logic [15:0] imm8,
   output logic [15:0] imm11,
   output aluOpT       aluOp,
   output logic        regWrite,
   output logic        memRead,
   output logic        memWrite,
   output logic        branchZero,
   output logic        branchNonZero,
   output logic        jump,
   output logic        halt,
   output logic        illegal
);

   logic [15:0] imm5;
   logic [15:0] rtData;
   logic [1:0]  bSel;
   logic [1:0]  destSel;
   logic        zeroExt;

   // immediates
   assign imm5  = zeroExt ? {11'b0, instr[4:0]} : {{11{instr[4]}}, instr[4:0]};
   assign imm8  = zeroExt ? {8'b0, instr[7:0]} : {{8{instr[7]}}, instr[7:0]};
   assign imm11 = {{5{instr[10]}}, instr[10:0]};   // j only, always signed

   assign destReg = (destSel == 2'd0) ? instr[10:8] :
                    (destSel == 2'd1) ? instr[7:5]  : instr[4:2];

   regFile u_regFile (
      .clk     (clk),
      .arstN   (arstN),
      .rdSelA  (instr[10:8]),
      .rdSelB  (instr[7:5]),
      .wrSel   (wbSel),
      .wrData  (wbData),
      .wrEn    (wbEn),
      .rdDataA (opA),
      .rdDataB (rtData)
   );

   // select code 3 is never decoded and gives zero
   assign opB = (bSel == 2'd0) ? rtData :
                (bSel == 2'd1) ? imm5   :
                (bSel == 2'd2) ? imm8   : 16'h0000;

   assign storeData = rtData;

   controlUnit u_controlUnit (
      .instr         (instr),
      .aluOp         (aluOp),
      .bSel          (bSel),
      .zeroExt       (zeroExt),
      .destSel       (destSel),
      .regWrite      (regWrite),
      .memRead       (memRead),
      .memWrite      (memWrite),
      .branchZero    (branchZero),
      .branchNonZero (branchNonZero),
      .jump          (jump),
      .halt          (halt),
      .illegal       (illegal)
   );

endmodule

// ==== verilog/controlUnit.sv ====
// purely combinational decoder; anything outside opcodeT is flagged illegal with no side effects
`timescale 1ns/100ps
module controlUnit import cpuPkg::*; (
   input  logic [15:0] instr,
   output aluOpT       aluOp,
   output logic [1:0]  bSel,      // 0 rt, 1 imm5, 2 imm8
   output logic        zeroExt,   // zero-extend immediates
   output logic [1:0]  destSel,   // 0 rs, 1 rt, 2 rd
   output logic        regWrite,
   output logic        memRead,
   output logic        memWrite,
   output logic        branchZero,
   output logic        branchNonZero,
   output logic        jump,
   output logic        halt,
   output logic        illegal
);

   opcodeT opcode;
   funcT   fn;

   assign opcode = opcodeT'(instr[15:11]);
   assign fn     = funcT'(instr[1:0]);

   always_comb begin
      // defaults describe a nop
      aluOp         = AluAdd;
      bSel          = 2'd0;
      zeroExt       = 1'b0;
      destSel       = 2'd1;
      regWrite      = 1'b0;
      memRead       = 1'b0;
      memWrite      = 1'b0;
      branchZero    = 1'b0;
      branchNonZero = 1'b0;
      jump          = 1'b0;
      halt          = 1'b0;
      illegal       = 1'b0;
      case (opcode)
         OpHalt: halt = 1'b1;
         OpNop:  ;
         OpAddi: begin
            bSel     = 2'd1;
            regWrite = 1'b1;
         end
         OpSubi: begin
            aluOp    = AluSub;
            bSel     = 2'd1;
            regWrite = 1'b1;
         end
         OpRfmt: begin
            destSel  = 2'd2;   // rd in [4:2]
            regWrite = 1'b1;
            case (fn)
               FnAdd: aluOp = AluAdd;
               FnSub: aluOp = AluSub;
               FnXor: aluOp = AluXor;
               FnAnd: aluOp = AluAnd;
            endcase
         end
         OpLbi: begin
            aluOp    = AluPassB;
            bSel     = 2'd2;
            destSel  = 2'd0;
            regWrite = 1'b1;
         end
         OpSlbi: begin
            aluOp    = AluMerge;
            bSel     = 2'd2;
            zeroExt  = 1'b1;   // low byte merged as is
            destSel  = 2'd0;
            regWrite = 1'b1;
         end
         OpLd: begin
            bSel     = 2'd1;   // address = rs + imm5
            regWrite = 1'b1;
            memRead  = 1'b1;
         end
         OpSt: begin
            bSel     = 2'd1;
            memWrite = 1'b1;   // data comes from rt port
         end
         OpBeqz: branchZero    = 1'b1;
         OpBnez: branchNonZero = 1'b1;
         OpJ:    jump          = 1'b1;
         default: illegal = 1'b1;
      endcase
   end

endmodule

// ==== verilog/regFile.sv ====
// eight 16-bit registers, combinational reads with no write bypass, async clear to zero
`timescale 1ns/100ps
module regFile (
   input  logic        clk,
   input  logic        arstN,
   input  logic [2:0]  rdSelA,   // rs port
   input  logic [2:0]  rdSelB,   // rt port
   input  logic [2:0]  wrSel,
   input  logic [15:0] wrData,
   input  logic        wrEn,
   output logic [15:0] rdDataA,
   output logic [15:0] rdDataB
);

   logic [15:0] regs [8];   // r0 is a normal register here

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrSel] <= wrData;   // new value visible from the next cycle
      end
   end

   assign rdDataA = regs[rdSelA];
   assign rdDataB = regs[rdSelB];

endmodule

// ==== verilog/cpuPkg.sv ====
// shared encodings for the 16-bit core; word width 16 and 8 registers are fixed by the encoding
package cpuPkg;

   // opcode field, instr[15:11]; any value not listed is illegal
   typedef enum logic [4:0] {
      OpHalt = 5'b00000,
      OpNop  = 5'b00001,
      OpJ    = 5'b00100,   // pc + 1 + sext(imm11)
      OpAddi = 5'b01000,
      OpSubi = 5'b01001,   // rs - imm5
      OpBeqz = 5'b01100,
      OpBnez = 5'b01101,
      OpSt   = 5'b10000,   // mem[rs + imm5] <- rt
      OpLd   = 5'b10001,
      OpSlbi = 5'b10010,   // rs <- (rs << 8) | zext(imm8)
      OpLbi  = 5'b11000,
      OpRfmt = 5'b11011    // add/sub/xor/and picked by func
   } opcodeT;

   // R-format function field, instr[1:0]
   typedef enum logic [1:0] {
      FnAdd = 2'b00,
      FnSub = 2'b01,
      FnXor = 2'b10,
      FnAnd = 2'b11
   } funcT;

   typedef enum logic [2:0] {
      AluAdd,
      AluSub,     // a - b
      AluXor,
      AluAnd,
      AluPassB,   // result is b for lbi
      AluMerge    // (a << 8) | b[7:0] for slbi
   } aluOpT;

   typedef enum logic [1:0] {
      FetchIdle,   // out of reset or halted
      FetchReq,    // request on the bus, buffer empty
      FetchHold    // buffer full, waiting for execute
   } fetchStateT;

endpackage
